// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exp_unit_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_TEXT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
hw/exp_pkg.sv
hw/fp_mul.sv
hw/fp_add.sv
hw/fp_recip_div.sv
hw/step_counter.sv
hw/exp_ctrl.sv
hw/exp_unit.sv
bench/exp_unit_props.sv
bench/exp_unit_tb.sv

// ==== bench/exp_unit_props.sv ====
`timescale 1ns/100ps

// control output checks, bound into exp_unit.
module exp_unit_props (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic done
);

  // done is a one cycle pulse.
  done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done stayed high for two cycles");

  // the cycle before done the unit is still working.
  done_after_busy: assert property (@(posedge clk) disable iff (rst) $rose(done) |-> $past(busy))
    else $error("done rose without busy in the cycle before");

  quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !busy && !done)
    else $error("busy or done high during reset");  // first reset edge still clears state.

endmodule

bind exp_unit exp_unit_props props_i (.clk(clk), .rst(rst), .busy(busy), .done(done));

// ==== bench/exp_unit_tb.sv ====
`timescale 1ns/100ps

// table cases first, then random inputs in -4 .. 4.
module exp_unit_tb;

  localparam int DEGREE  = 5;
  localparam int TIMEOUT = 100;  // cycles allowed for one operation.
  localparam int N_CASES = 11;
  localparam int N_RAND  = 20;

  logic         clk = 1'b0;
  logic         rst;
  logic         start;
  exp_pkg::fp_t x;
  logic         busy;
  logic         done;
  exp_pkg::fp_t result;

  // per case: name, input, cycles to done, ulp tolerance, extra start while busy.
  string       names [N_CASES] = '{"pos_zero", "neg_zero", "half", "one", "two", "three_q",
                                   "neg_half", "neg_one", "neg_two", "busy_start_pos",
                                   "busy_start_neg"};
  logic [31:0] xs    [N_CASES] = '{32'h0000_0000, 32'h8000_0000, 32'h3f00_0000, 32'h3f80_0000,
                                   32'h4000_0000, 32'h4050_0000, 32'hbf00_0000, 32'hbf80_0000,
                                   32'hc000_0000, 32'h3f80_0000, 32'hbf80_0000};
  int          lats  [N_CASES] = '{17, 43, 17, 17, 17, 17, 43, 43, 43, 17, 43};
  int          tols  [N_CASES] = '{0, 0, 64, 64, 64, 64, 64, 64, 64, 64, 64};
  bit          pokes [N_CASES] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1};

  always #5 clk = ~clk;

  exp_unit #(.DEGREE(DEGREE)) dut_i (
    .clk(clk), .rst(rst), .start(start), .x(x), .busy(busy), .done(done), .result(result)
  );

  // single precision bits to a real, zero exponent reads as zero.
  function automatic real fp_to_real(input logic [31:0] f);
    logic [63:0] d;
    if (f[30:23] == 8'd0) return 0.0;
    d = {f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0};  // rebias 127 to 1023.
    return $bitstoreal(d);
  endfunction

  // real to single precision, truncating the mantissa.
  function automatic logic [31:0] real_to_fp(input real r);
    logic [63:0] d;
    logic [10:0] e;
    if (r == 0.0) return 32'd0;
    d = $realtobits(r);
    e = d[62:52];
    return {d[63], 8'(e - 11'd896), d[51:29]};
  endfunction

  // taylor sum of e^|x| up to DEGREE, inverted when x is negative.
  function automatic logic [31:0] expected_fp(input logic [31:0] xv);
    real mag;
    real term;
    real sum;
    mag  = fp_to_real({1'b0, xv[30:0]});
    term = 1.0;
    sum  = 1.0;
    for (int k = 1; k <= DEGREE; k++) begin
      term = term * mag / real'(k);
      sum  = sum + term;
    end
    if (xv[31]) sum = 1.0 / sum;
    return real_to_fp(sum);
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual, input int tol);
    longint diff;
    diff = longint'({32'd0, expected}) - longint'({32'd0, actual});
    if (diff < 0) diff = -diff;
    if (diff > longint'(tol)) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // one operation, called and left 1 ns after a rising edge.
  task automatic apply_case(input string name, input logic [31:0] xv, input int lat,
                            input int tol, input bit poke, input int gap);
    int          n;
    logic [31:0] held;
    n     = 0;
    x     = xv;
    start = 1'b1;
    do begin
      @(posedge clk);
      #1;
      n++;
      start = poke && (n == 4);  // lands while busy, must be dropped.
      if (start) x = 32'hc080_0000;
      if (!done) compare($sformatf("%s busy", name), 32'd1, {31'd0, busy}, 0);
    end while (!done && n < TIMEOUT);
    if (!done) begin
      $display("done never came for %s within %0d cycles", name, TIMEOUT);
      $display("Checks failed");
      $fatal(1, "timeout waiting for done");
    end
    compare($sformatf("%s latency", name), lat, n, 0);
    compare(name, expected_fp(xv), result, tol);
    held = result;
    repeat (gap) begin
      @(posedge clk);
      #1;
      compare($sformatf("%s hold", name), held, result, 0);
    end
  endtask

  initial begin
    real         r;
    logic [31:0] xv;
    rst   = 1'b1;
    start = 1'b0;
    x     = '0;
    void'($urandom(56));
    repeat (16) @(posedge clk);
    #1;
    compare("reset_flags", 32'd0, {30'd0, busy, done}, 0);
    compare("reset_result", exp_pkg::FP_ONE, result, 0);
    rst = 1'b0;
    @(posedge clk);
    #1;
    compare("idle_flags", 32'd0, {30'd0, busy, done}, 0);
    compare("idle_result", exp_pkg::FP_ONE, result, 0);

    for (int i = 0; i < N_CASES; i++) begin
      apply_case(names[i], xs[i], lats[i], tols[i], pokes[i], 1);
    end

    for (int i = 0; i < N_RAND; i++) begin
      r  = real'($urandom % 80001) / 10000.0 - 4.0;
      xv = real_to_fp(r);
      apply_case($sformatf("rand_%0d", i), xv, 3 * DEGREE + 2 + (xv[31] ? 26 : 0), 64,
                 1'b0, 1 + int'($urandom % 4));
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== hw/exp_ctrl.sv ====
`timescale 1ns/100ps

// sequencer for the term loop and the optional inversion.
module exp_ctrl #(
  parameter int DEGREE = 5
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       neg,
  input  logic       cnt_last,
  output logic       busy,
  output logic       done,
  output logic       term_load,
  output logic       term_from_k,
  output logic       sum_load,
  output logic       div_start,
  output logic       div_step,
  output logic       cnt_load,
  output logic       cnt_dec,
  output logic [4:0] cnt_value,
  output logic [3:0] k
);

  exp_pkg::exp_state_t state;
  exp_pkg::exp_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      exp_pkg::IDLE:       if (start) state_next = exp_pkg::TERM_MUL_X;
      exp_pkg::TERM_MUL_X: state_next = exp_pkg::TERM_MUL_K;
      exp_pkg::TERM_MUL_K: state_next = exp_pkg::SUM_ADD;
      exp_pkg::SUM_ADD: begin
        // cnt_last marks the sum of term k = DEGREE.
        if (!cnt_last) state_next = exp_pkg::TERM_MUL_X;
        else if (neg) state_next = exp_pkg::INV_LOAD;
        else state_next = exp_pkg::FINISH;
      end
      exp_pkg::INV_LOAD:   state_next = exp_pkg::INV_STEP;
      exp_pkg::INV_STEP:   if (cnt_last) state_next = exp_pkg::FINISH;
      default:             state_next = exp_pkg::IDLE;  // FINISH.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= exp_pkg::IDLE;
      k     <= '0;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= (state == exp_pkg::FINISH);  // one cycle after FINISH.
      if (state == exp_pkg::IDLE && start) k <= 4'd1;
      else if (state == exp_pkg::SUM_ADD) k <= k + 4'd1;
    end
  end

  assign busy        = (state != exp_pkg::IDLE);
  assign term_load   = (state == exp_pkg::TERM_MUL_X) || (state == exp_pkg::TERM_MUL_K);
  assign term_from_k = (state == exp_pkg::TERM_MUL_K);
  assign sum_load    = (state == exp_pkg::SUM_ADD);
  assign div_start   = (state == exp_pkg::INV_LOAD);
  assign div_step    = (state == exp_pkg::INV_STEP);

  // the counter first runs over the terms, then over the quotient bits.
  assign cnt_load  = (state == exp_pkg::IDLE && start) || (state == exp_pkg::INV_LOAD);
  assign cnt_value = (state == exp_pkg::INV_LOAD) ? 5'(exp_pkg::DIV_STEPS) : 5'(DEGREE);
  assign cnt_dec   = (state == exp_pkg::SUM_ADD) || (state == exp_pkg::INV_STEP);

endmodule

// ==== hw/exp_pkg.sv ====
package exp_pkg;

  // ieee-754 single precision word.
  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [22:0] man;
  } fp_t;

  localparam fp_t FP_ONE = 32'h3f80_0000;  // 1.0

  localparam int MAX_DEGREE = 8;  // highest index held in the 1/k table.
  localparam int DIV_STEPS = 25;  // quotient bits, hidden bit plus 23 plus one spare.

  typedef enum logic [2:0] {
    IDLE,
    TERM_MUL_X,
    TERM_MUL_K,
    SUM_ADD,
    INV_LOAD,
    INV_STEP,
    FINISH
  } exp_state_t;

  // 1/k rounded to nearest, k = 1 .. MAX_DEGREE.
  function automatic fp_t recip_k(input logic [3:0] k);
    case (k)
      4'd2:    recip_k = 32'h3f00_0000;
      4'd3:    recip_k = 32'h3eaa_aaab;
      4'd4:    recip_k = 32'h3e80_0000;
      4'd5:    recip_k = 32'h3e4c_cccd;
      4'd6:    recip_k = 32'h3e2a_aaab;
      4'd7:    recip_k = 32'h3e12_4925;
      4'd8:    recip_k = 32'h3e00_0000;
      default: recip_k = FP_ONE;  // k = 1.
    endcase
  endfunction

endpackage

// ==== hw/exp_unit.sv ====
`timescale 1ns/100ps

// e^x by a Taylor sum on |x|, inverted for negative x.
module exp_unit #(
  parameter int DEGREE = 5
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  exp_pkg::fp_t x,
  output logic         busy,
  output logic         done,
  output exp_pkg::fp_t result
);

  exp_pkg::fp_t x_mag;
  exp_pkg::fp_t term;
  exp_pkg::fp_t sum;
  exp_pkg::fp_t mul_b;
  exp_pkg::fp_t mul_y;
  exp_pkg::fp_t add_y;
  exp_pkg::fp_t div_q;
  logic         neg;
  logic         accept;
  logic         term_load, term_from_k, sum_load;
  logic         div_start, div_step;
  logic         cnt_load, cnt_dec, cnt_last;
  logic [4:0]   cnt_value;
  logic [3:0]   k;

  assign accept = start && !busy;  // a start while busy is dropped.

  always_ff @(posedge clk) begin
    if (rst) begin
      neg <= 1'b0;
      sum <= exp_pkg::FP_ONE;
    end else if (accept) begin
      neg <= x.sign;
      sum <= exp_pkg::FP_ONE;
    end else if (sum_load) begin
      sum <= add_y;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      x_mag <= {1'b0, x.exp, x.man};
      term  <= exp_pkg::FP_ONE;
    end else if (term_load) begin
      term <= mul_y;  // term * |x|, then * 1/k.
    end
  end

  assign mul_b = term_from_k ? exp_pkg::recip_k(k) : x_mag;

  // sum, neg and the quotient are all stable from FINISH until the next start.
  assign result = neg ? div_q : sum;

  exp_ctrl #(.DEGREE(DEGREE)) ctrl_i (
    .clk(clk), .rst(rst), .start(start), .neg(neg), .cnt_last(cnt_last),
    .busy(busy), .done(done), .term_load(term_load), .term_from_k(term_from_k),
    .sum_load(sum_load), .div_start(div_start), .div_step(div_step),
    .cnt_load(cnt_load), .cnt_dec(cnt_dec), .cnt_value(cnt_value), .k(k)
  );

  step_counter cnt_i (
    .clk(clk), .rst(rst), .load(cnt_load), .value(cnt_value), .dec(cnt_dec), .last(cnt_last)
  );

  fp_mul mul_i (.a(term), .b(mul_b), .y(mul_y));

  fp_add add_i (.a(sum), .b(term), .y(add_y));

  fp_recip_div div_i (
    .clk(clk), .rst(rst), .start(div_start), .step(div_step), .d(sum), .q(div_q)
  );

endmodule

// ==== hw/fp_add.sv ====
`timescale 1ns/100ps

// single precision add, both signs, truncating.
module fp_add (
  input  exp_pkg::fp_t a,
  input  exp_pkg::fp_t b,
  output exp_pkg::fp_t y
);

  exp_pkg::fp_t      big_op;
  exp_pkg::fp_t      small_op;
  logic [7:0]        shift;
  logic [27:0]       big_s;  // carry, hidden bit, 23 bits, 3 guard bits.
  logic [27:0]       small_s;
  logic [27:0]       raw;
  logic [27:0]       norm;
  logic [4:0]        lz;
  logic signed [9:0] exp_r;

  // order by magnitude so the difference never goes negative.
  always_comb begin
    if ({a.exp, a.man} >= {b.exp, b.man}) begin
      big_op   = a;
      small_op = b;
    end else begin
      big_op   = b;
      small_op = a;
    end
  end

  always_comb begin
    shift = big_op.exp - small_op.exp;
    big_s = {2'b01, big_op.man, 3'b000};
    if (small_op.exp == 8'd0 || shift > 8'd27) begin
      small_s = '0;  // zero or shifted entirely out.
    end else begin
      small_s = {2'b01, small_op.man, 3'b000} >> shift;
    end
    if (big_op.sign == small_op.sign) begin
      raw = big_s + small_s;
    end else begin
      raw = big_s - small_s;
    end
  end

  // leading-zero count below the carry bit, the highest set bit wins.
  always_comb begin
    lz = '0;
    for (int i = 0; i < 27; i++) begin
      if (raw[i]) lz = 5'(26 - i);
    end
  end

  always_comb begin
    if (raw[27]) begin
      norm  = raw >> 1;  // carry out.
      exp_r = $signed({2'b00, big_op.exp}) + 10'sd1;
    end else begin
      norm  = raw << lz;
      exp_r = $signed({2'b00, big_op.exp}) - $signed({5'd0, lz});
    end
  end

  always_comb begin
    y.sign = big_op.sign;
    y.exp  = exp_r[7:0];
    y.man  = norm[25:3];
    if (big_op.exp == 8'd0 || raw == '0 || exp_r <= 10'sd0) begin
      y = '0;  // exact cancellation or underflow gives +0.
    end else if (exp_r >= 10'sd255) begin
      y.exp = 8'hff;
      y.man = 23'd0;
    end
  end

endmodule

// ==== hw/fp_mul.sv ====
`timescale 1ns/100ps

// single precision multiply, truncating, no denormals.
module fp_mul (
  input  exp_pkg::fp_t a,
  input  exp_pkg::fp_t b,
  output exp_pkg::fp_t y
);

  logic [47:0]       prod;
  logic [22:0]       man;
  logic signed [9:0] exp_sum;
  logic              sign;
  logic              zero_in;

  assign sign    = a.sign ^ b.sign;
  assign zero_in = (a.exp == 8'd0) || (b.exp == 8'd0);  // denormals count as zero.

  always_comb begin
    prod = 48'({1'b1, a.man}) * 48'({1'b1, b.man});
    // product of two [1,2) values lies in [1,4).
    if (prod[47]) begin
      man     = prod[46:24];
      exp_sum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - 10'sd126;
    end else begin
      man     = prod[45:23];
      exp_sum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - 10'sd127;
    end
  end

  always_comb begin
    y.sign = sign;
    if (zero_in || exp_sum <= 10'sd0) begin
      y.exp = 8'd0;  // flush to zero.
      y.man = 23'd0;
    end else if (exp_sum >= 10'sd255) begin
      y.exp = 8'hff;  // saturate to infinity.
      y.man = 23'd0;
    end else begin
      y.exp = exp_sum[7:0];
      y.man = man;
    end
  end

endmodule

// ==== hw/fp_recip_div.sv ====
`timescale 1ns/100ps

// restoring divider for 1/d, one quotient bit per step.
module fp_recip_div (
  input  logic         clk,
  input  logic         rst,
  input  logic         start,
  input  logic         step,
  input  exp_pkg::fp_t d,
  output exp_pkg::fp_t q
);

  logic [25:0]       rem;
  logic [25:0]       diff;
  logic [23:0]       dsig;
  logic [24:0]       quo;  // bit 24 has weight 2^0.
  logic [7:0]        dexp;
  logic              dsign;
  logic signed [9:0] qexp;

  assign diff = rem - {2'b00, dsig};  // bit 25 set means rem < dsig.

  always_ff @(posedge clk) begin
    if (rst) begin
      quo  <= '0;
      dexp <= 8'd127;
    end else if (start) begin
      rem   <= 26'h080_0000;  // 1.0 on the divisor's scale.
      dsig  <= {1'b1, d.man};
      dexp  <= d.exp;
      dsign <= d.sign;
      quo   <= '0;
    end else if (step) begin
      if (!diff[25]) begin
        rem <= {diff[24:0], 1'b0};
        quo <= {quo[23:0], 1'b1};
      end else begin
        rem <= {rem[24:0], 1'b0};
        quo <= {quo[23:0], 1'b0};
      end
    end
  end

  // quotient lies in (0.5, 1], one left shift when bit 24 is clear.
  assign qexp = 10'sd254 - $signed({2'b00, dexp}) - (quo[24] ? 10'sd0 : 10'sd1);

  // q decodes held registers only.
  always_comb begin
    q.sign = dsign;
    if (dexp == 8'd0) begin
      q.exp = 8'hff;
      q.man = 23'd0;
    end else if (qexp <= 10'sd0) begin
      q.exp = 8'd0;
      q.man = 23'd0;
    end else begin
      q.exp = qexp[7:0];
      q.man = quo[24] ? quo[23:1] : quo[22:0];
    end
  end

endmodule

// ==== hw/step_counter.sv ====
`timescale 1ns/100ps

// down-counter with load, last is high while the count is one.
module step_counter (
  input  logic       clk,
  input  logic       rst,
  input  logic       load,
  input  logic [4:0] value,
  input  logic       dec,
  output logic       last
);

  logic [4:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= value;
    end else if (dec && count != 5'd0) begin
      count <= count - 5'd1;  // holds at zero.
    end
  end

  assign last = (count == 5'd1);

endmodule
